// File: design/dmaPkg.sv
package dmaPkg;

  localparam int NUM_CH = 4;

  typedef logic [27:0] addrT;   // byte address
  typedef logic [31:0] dataT;
  typedef logic [13:0] countT;  // units per transfer
  typedef logic [8:0]  lineT;   // display position counter

  localparam lineT HBLANK_POS = 9'd240;
  localparam lineT VBLANK_POS = 9'd160;

  // channels 1 and 2 can be paced by the sound FIFOs
  localparam logic [NUM_CH-1:0] SOUND_CH = 4'b0110;

  localparam addrT HALF_STEP = 28'd2;
  localparam addrT WORD_STEP = 28'd4;

  typedef enum logic [1:0] {
    ADDR_INC        = 2'b00,
    ADDR_DEC        = 2'b01,
    ADDR_FIXED      = 2'b10,
    ADDR_INC_RELOAD = 2'b11   // destination only
  } addrModeT;

  typedef enum logic [1:0] {
    START_NOW     = 2'b00,
    START_VBLANK  = 2'b01,
    START_HBLANK  = 2'b10,
    START_SPECIAL = 2'b11
  } startModeT;

  typedef enum logic [1:0] {
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } busSizeT;

  typedef enum logic [2:0] {
    CH_OFF, CH_IDLE, CH_QUEUED, CH_READ, CH_WRITE, CH_PREEMPTED
  } chStateT;

  typedef struct packed {
    addrT      srcAddr;
    addrT      dstAddr;
    countT     count;
    addrModeT  dstMode;
    addrModeT  srcMode;
    logic      repeatEn;
    logic      wordSize;
    startModeT startMode;
    logic      irqEn;
    logic      enable;
  } dmaCfgT;

  typedef struct packed {
    addrT    addr;
    dataT    wdata;
    busSizeT size;
    logic    wen;
    logic    valid;
  } dmaBusT;

endpackage

// File: design/dmaStartSync.sv
`timescale 1ns/1ps

module dmaStartSync import dmaPkg::*; (
  input  logic                clk,
  input  logic                rst_b,
  input  dmaCfgT [NUM_CH-1:0] cfg,
  input  lineT                hcount,
  input  lineT                vcount,
  input  logic [1:0]          soundReq,
  output logic [NUM_CH-1:0]   start,
  output logic [NUM_CH-1:0]   specialStop
);

  logic hMatch, vMatch;
  logic hPrev, vPrev;
  logic hPulse, vPulse;
  logic [NUM_CH-1:0] soundVec;

  assign hMatch = (hcount == HBLANK_POS);
  assign vMatch = (vcount == VBLANK_POS);

  // counters sit on the blank position for many cycles, so only the
  // first cycle of each match becomes a trigger
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      hPrev  <= 1'b0;
      vPrev  <= 1'b0;
      hPulse <= 1'b0;
      vPulse <= 1'b0;
    end else begin
      hPrev  <= hMatch;
      vPrev  <= vMatch;
      hPulse <= hMatch && !hPrev;
      vPulse <= vMatch && !vPrev;
    end
  end

  assign soundVec = {1'b0, soundReq, 1'b0} & SOUND_CH;  // fifo requests by channel slot

  always_comb begin
    logic trig;
    for (int i = 0; i < NUM_CH; i++) begin
      case (cfg[i].startMode)
        START_NOW:    trig = 1'b1;
        START_VBLANK: trig = vPulse;
        START_HBLANK: trig = hPulse;
        default:      trig = soundVec[i];  // stays low on 0 and 3
      endcase
      start[i] = trig && cfg[i].enable;

      // special timing on a non-sound channel just shuts off at vblank
      specialStop[i] = cfg[i].enable && !SOUND_CH[i] && vPulse &&
                       (cfg[i].startMode == START_SPECIAL);
    end
  end

endmodule

// File: design/dmaChannel.sv
`timescale 1ns/1ps

module dmaChannel import dmaPkg::*; #(
  parameter bit soundCh = 1'b0
) (
  input  logic   clk,
  input  logic   rst_b,
  input  dmaCfgT cfg,
  input  logic   start,
  input  logic   memWait,
  input  dataT   rdata,
  input  logic   preempted,
  input  logic   allowedToBegin,
  output dmaBusT bus,
  output logic   active,
  output logic   midUnit,
  output logic   irq,
  output logic   disableDma
);

  chStateT  state, nextState;
  dmaCfgT   cfgQ;             // cfg from the previous cycle
  addrT     srcAddr, dstAddr;
  addrT     step;
  countT    unitsLeft;
  dataT     dataQ;
  addrModeT dstMode;
  logic     soundMode;
  logic     wordXfer;
  logic     loadCfg;
  logic     canBegin;
  logic     readDone, writeDone;
  logic     lastUnit;

  function automatic addrT stepAddr(addrT a, addrModeT mode, addrT inc);
    case (mode)
      ADDR_DEC:   return a - inc;
      ADDR_FIXED: return a;
      default:    return a + inc;
    endcase
  endfunction

  // fifo feeding always moves words into one fixed port
  assign soundMode = soundCh && (cfg.startMode == START_SPECIAL);
  assign wordXfer  = cfg.wordSize || soundMode;
  assign dstMode   = soundMode ? ADDR_FIXED : cfg.dstMode;
  assign step      = wordXfer ? WORD_STEP : HALF_STEP;

  assign loadCfg   = cfg.enable && (cfg != cfgQ) &&
                     ((state == CH_OFF) || (state == CH_IDLE));
  assign canBegin  = !preempted && !memWait && allowedToBegin;
  assign readDone  = (state == CH_READ) && !memWait;
  assign writeDone = (state == CH_WRITE) && !memWait;
  assign lastUnit  = (unitsLeft == countT'(1));

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= CH_OFF;
      cfgQ  <= '0;
    end else begin
      state <= nextState;
      cfgQ  <= cfg;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      CH_OFF: begin
        if (loadCfg) nextState = CH_IDLE;
      end
      CH_IDLE: begin
        if (!cfg.enable) begin
          nextState = CH_OFF;
        end else if (start && !loadCfg) begin
          nextState = canBegin ? CH_READ : CH_QUEUED;  // keep a pulse start pending
        end
      end
      CH_QUEUED, CH_PREEMPTED: begin
        if (!cfg.enable) begin
          nextState = CH_OFF;
        end else if (canBegin) begin
          nextState = CH_READ;
        end
      end
      CH_READ: begin
        if (!memWait) nextState = CH_WRITE;
      end
      CH_WRITE: begin
        if (!memWait) begin
          if (lastUnit) begin
            nextState = cfg.repeatEn ? CH_IDLE : CH_OFF;
          end else if (!cfg.enable) begin
            nextState = CH_OFF;
          end else if (preempted) begin
            nextState = CH_PREEMPTED;  // give way only at a unit boundary
          end else begin
            nextState = CH_READ;
          end
        end
      end
      default: nextState = CH_OFF;
    endcase
  end

  always_ff @(posedge clk) begin
    if (loadCfg) begin
      srcAddr   <= cfg.srcAddr;
      dstAddr   <= cfg.dstAddr;
      unitsLeft <= cfg.count;
    end
    if (readDone) begin
      srcAddr <= stepAddr(srcAddr, cfg.srcMode, step);
      // halfword reads pick their lane by address bit 1
      dataQ   <= wordXfer ? rdata : {16'h0000, srcAddr[1] ? rdata[31:16] : rdata[15:0]};
    end
    if (writeDone) begin
      if (lastUnit && cfg.repeatEn) begin
        unitsLeft <= cfg.count;
        dstAddr   <= (dstMode == ADDR_INC_RELOAD) ? cfg.dstAddr :
                     stepAddr(dstAddr, dstMode, step);
      end else begin
        unitsLeft <= unitsLeft - countT'(1);
        dstAddr   <= stepAddr(dstAddr, dstMode, step);
      end
    end
  end

  always_comb begin
    bus.addr  = (state == CH_WRITE) ? dstAddr : srcAddr;
    bus.wdata = wordXfer ? dataQ : {dataQ[15:0], dataQ[15:0]};  // halfword in both lanes
    bus.size  = wordXfer ? SIZE_WORD : SIZE_HALF;
    bus.wen   = (state == CH_WRITE);
    bus.valid = (state == CH_READ) || (state == CH_WRITE);
  end

  // a channel about to begin counts as active so higher indices hold off
  assign active = (state == CH_QUEUED) || (state == CH_READ) ||
                  (state == CH_WRITE) || (state == CH_PREEMPTED) ||
                  ((state == CH_IDLE) && start);
  assign midUnit    = (state == CH_WRITE);
  assign irq        = writeDone && lastUnit && cfg.irqEn;
  assign disableDma = writeDone && lastUnit && !cfg.repeatEn;

  // the unit counter never runs dry while the channel holds the bus
  assert property (@(posedge clk) disable iff (!rst_b)
    bus.valid |-> (unitsLeft != '0));

  assert property (@(posedge clk) disable iff (!rst_b)
    bus.valid && memWait |=> bus.valid && $stable(bus.addr) && $stable(bus.wen) &&
                             $stable(bus.wdata));

  assert property (@(posedge clk) disable iff (!rst_b)
    loadCfg |-> (cfg.count != '0));

  assert property (@(posedge clk) disable iff (!rst_b)
    bus.valid |-> ((bus.size == SIZE_WORD) ? (bus.addr[1:0] == 2'b00) : !bus.addr[0]));

endmodule

// File: design/dmaBusArbiter.sv
`timescale 1ns/1ps

module dmaBusArbiter import dmaPkg::*; (
  input  dmaBusT [NUM_CH-1:0] chBus,
  input  logic [NUM_CH-1:0]   active,
  input  logic [NUM_CH-1:0]   midUnit,
  output logic [NUM_CH-1:0]   preempted,
  output logic                allowedToBegin,
  output dmaBusT              bus
);

  logic [NUM_CH-1:0] chValid;
  logic busBusy;

  // channel i yields to anything active below it
  always_comb begin
    preempted[0] = 1'b0;
    for (int i = 1; i < NUM_CH; i++) begin
      preempted[i] = preempted[i-1] || active[i-1];
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      chValid[i] = chBus[i].valid;
    end
  end

  assign busBusy = |chValid;

  // no new unit while another is half done or a read is still on the bus
  assign allowedToBegin = !(|midUnit) && !busBusy;

  always_comb begin
    bus = '0;
    for (int i = NUM_CH - 1; i >= 0; i--) begin
      if (chValid[i]) bus = chBus[i];  // lowest index ends up winning
    end
  end

  assertOneMidUnit: assert final ($onehot0(midUnit));

endmodule

// File: design/dmaTop.sv
`timescale 1ns/1ps

module dmaTop import dmaPkg::*; (
  input  logic                clk,
  input  logic                rst_b,
  input  dmaCfgT [NUM_CH-1:0] cfg,
  input  lineT                hcount,
  input  lineT                vcount,
  input  logic [1:0]          soundReq,
  input  logic                memWait,
  input  dataT                rdata,
  output dmaBusT              bus,
  output logic                active,
  output logic [NUM_CH-1:0]   irq,
  output logic [NUM_CH-1:0]   disableDma
);

  logic [NUM_CH-1:0] start;
  logic [NUM_CH-1:0] specialStop;
  logic [NUM_CH-1:0] chActive;
  logic [NUM_CH-1:0] midUnit;
  logic [NUM_CH-1:0] preempted;
  logic [NUM_CH-1:0] chDisable;
  dmaBusT [NUM_CH-1:0] chBus;
  logic allowedToBegin;

  dmaStartSync uStartSync (
    .clk         (clk),
    .rst_b       (rst_b),
    .cfg         (cfg),
    .hcount      (hcount),
    .vcount      (vcount),
    .soundReq    (soundReq),
    .start       (start),
    .specialStop (specialStop)
  );

  for (genvar i = 0; i < NUM_CH; i++) begin : genCh
    dmaChannel #(.soundCh(SOUND_CH[i])) uChannel (
      .clk            (clk),
      .rst_b          (rst_b),
      .cfg            (cfg[i]),
      .start          (start[i]),
      .memWait        (memWait),
      .rdata          (rdata),
      .preempted      (preempted[i]),
      .allowedToBegin (allowedToBegin),
      .bus            (chBus[i]),
      .active         (chActive[i]),
      .midUnit        (midUnit[i]),
      .irq            (irq[i]),
      .disableDma     (chDisable[i])
    );
  end

  dmaBusArbiter uArbiter (
    .chBus          (chBus),
    .active         (chActive),
    .midUnit        (midUnit),
    .preempted      (preempted),
    .allowedToBegin (allowedToBegin),
    .bus            (bus)
  );

  assign disableDma = chDisable | specialStop;  // either way the enable bit gets cleared
  assign active     = |chActive;

endmodule

// File: bench/dmaClockGen.sv
`timescale 1ns/1ps

module dmaClockGen (
  output logic clk,
  output logic rst_b
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    rst_b = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk) rst_b = 1'b1;
  end

endmodule

// File: bench/dmaMemModel.sv
`timescale 1ns/1ps

module dmaMemModel import dmaPkg::*; (
  input  logic   clk,
  input  logic   rst_b,
  input  dmaBusT bus,
  input  logic   stallEn,
  output logic   memWait,
  output dataT   rdata
);

  dataT    mem [addrT];   // keyed by word address
  int      waitLeft;
  addrT    logAddr [$];
  dataT    logData [$];
  busSizeT logSize [$];

  function automatic dataT peekWord(addrT a);
    addrT w;
    w = a >> 2;
    if (mem.exists(w)) return mem[w];
    return {4'h0, a[27:2], 2'b00} ^ 32'h5a5a_c3c3;  // untouched words
  endfunction

  task automatic preload(addrT base, int words);
    for (int i = 0; i < words; i++) begin
      mem[(base >> 2) + addrT'(i)] = $urandom;
    end
  endtask

  function automatic void clearLog();
    logAddr.delete();
    logData.delete();
    logSize.delete();
  endfunction

  // inputs to the DUT change on the falling edge only
  always @(negedge clk) begin
    memWait <= bus.valid && (waitLeft != 0);
    rdata   <= peekWord(bus.addr);
  end

  always @(posedge clk or negedge rst_b) begin
    dataT w;
    if (!rst_b) begin
      waitLeft = 0;
    end else if (bus.valid) begin
      if (memWait) begin
        waitLeft = waitLeft - 1;
      end else begin
        if (bus.wen) begin
          w = peekWord(bus.addr);
          if (bus.size == SIZE_WORD) w = bus.wdata;
          else if (bus.addr[1]) w[31:16] = bus.wdata[31:16];
          else w[15:0] = bus.wdata[15:0];
          mem[bus.addr >> 2] = w;
          logAddr.push_back(bus.addr);
          logData.push_back(bus.wdata);
          logSize.push_back(bus.size);
        end
        waitLeft = stallEn ? int'($urandom % 4) : 0;  // stall for the next access
      end
    end
  end

  initial begin
    memWait = 1'b0;
    rdata   = '0;
  end

endmodule

// File: bench/dmaTb.sv
`timescale 1ns/1ps

module dmaTb import dmaPkg::*; ();

  logic clk, rst_b;
  dmaCfgT [NUM_CH-1:0] cfg;
  lineT hcount, vcount;
  logic [1:0] soundReq;
  logic memWait, stallEn, active;
  dataT rdata;
  dmaBusT bus;
  logic [NUM_CH-1:0] irq, disableDma;

  int errors = 0;
  int checks = 0;
  int irqCnt [NUM_CH];
  int disCnt [NUM_CH];
  addrT    expAddr [$];
  dataT    expData [$];
  busSizeT expSize [$];

  dmaClockGen clkGen (.clk(clk), .rst_b(rst_b));

  dmaTop dut (
    .clk(clk), .rst_b(rst_b), .cfg(cfg), .hcount(hcount), .vcount(vcount),
    .soundReq(soundReq), .memWait(memWait), .rdata(rdata), .bus(bus),
    .active(active), .irq(irq), .disableDma(disableDma)
  );

  dmaMemModel mem (
    .clk(clk), .rst_b(rst_b), .bus(bus), .stallEn(stallEn),
    .memWait(memWait), .rdata(rdata)
  );

  always @(posedge clk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (irq[i]) irqCnt[i]++;
      if (disableDma[i]) disCnt[i]++;
    end
  end

  function automatic addrT advance(addrT a, addrModeT m, addrT inc);
    if (m == ADDR_DEC) return a - inc;
    if (m == ADDR_FIXED) return a;
    return a + inc;
  endfunction

  function automatic dmaCfgT makeCfg(addrT src, addrT dst, int count, addrModeT sm,
                                     addrModeT dm, bit rep, bit word, startModeT st);
    dmaCfgT c;
    c = '0;
    c.srcAddr = src;
    c.dstAddr = dst;
    c.count = countT'(count);
    c.srcMode = sm;
    c.dstMode = dm;
    c.repeatEn = rep;
    c.wordSize = word;
    c.startMode = st;
    c.irqEn = 1'b1;
    c.enable = 1'b1;
    return c;
  endfunction

  // expected writes worked out from the address and lane rules
  task automatic buildExpected(addrT src, addrT dst, int count, addrModeT sm,
                               addrModeT dm, bit word, int passes);
    addrT s, d, inc;
    dataT w;
    logic [15:0] h;
    expAddr.delete();
    expData.delete();
    expSize.delete();
    inc = word ? 28'd4 : 28'd2;
    s = src;
    d = dst;
    for (int p = 0; p < passes; p++) begin
      if (p > 0 && dm == ADDR_INC_RELOAD) d = dst;
      for (int k = 0; k < count; k++) begin
        w = mem.peekWord(s);
        h = s[1] ? w[31:16] : w[15:0];
        expAddr.push_back(d);
        expData.push_back(word ? w : {h, h});
        expSize.push_back(word ? SIZE_WORD : SIZE_HALF);
        s = advance(s, sm, inc);
        d = advance(d, dm, inc);
      end
    end
  endtask

  task automatic checkRegion(string name, addrT lo, addrT hi);
    int j;
    j = 0;
    for (int i = 0; i < mem.logAddr.size(); i++) begin
      if (mem.logAddr[i] >= lo && mem.logAddr[i] < hi) begin
        checks++;
        if (j >= expAddr.size()) begin
          $display("%s: extra write to %h", name, mem.logAddr[i]);
          errors++;
        end else begin
          if (mem.logAddr[i] != expAddr[j]) begin
            $display("mismatch %s addr exp %h got %h", name, expAddr[j], mem.logAddr[i]);
            errors++;
          end
          if (mem.logData[i] != expData[j]) begin
            $display("mismatch %s data exp %h got %h", name, expData[j], mem.logData[i]);
            errors++;
          end
          if (mem.logSize[i] != expSize[j]) begin
            $display("mismatch %s size exp %0d got %0d", name, expSize[j], mem.logSize[i]);
            errors++;
          end
        end
        j++;
      end
    end
    if (j < expAddr.size()) begin
      $display("%s: only %0d of %0d writes seen", name, j, expAddr.size());
      errors++;
    end
  endtask

  task automatic waitPulse(int ch, bit useIrq, int limit, string name);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(useIrq ? irq[ch] : disableDma[ch]) && n < limit);
    if (n >= limit) begin
      $display("%s: timed out waiting for channel %0d to finish", name, ch);
      errors++;
    end
  endtask

  task automatic runTransfer(int ch, dmaCfgT c, int limit, string name);
    @(negedge clk) cfg[ch] = c;
    waitPulse(ch, 1'b0, limit, name);
    @(negedge clk) cfg[ch].enable = 1'b0;  // what the register file would do
    checks++;
    if (active !== 1'b0) begin
      $display("mismatch %s active exp 0 got %b", name, active);
      errors++;
    end
  endtask

  task automatic waitWrites(int n, int limit, string name);
    int t;
    t = 0;
    while (mem.logAddr.size() < n && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (t >= limit) begin
      $display("%s: timed out waiting for %0d writes", name, n);
      errors++;
    end
  endtask

  task automatic pulseHblank();
    @(negedge clk) hcount = HBLANK_POS;
    repeat (4) @(negedge clk);
    hcount = 9'd0;
  endtask

  initial begin
    int first, last, n0, n3, i0, d0, t;
    addrT src, dst;
    addrModeT sm, dm;
    void'($urandom(11791));
    cfg = '0;
    hcount = '0;
    vcount = '0;
    soundReq = '0;
    stallEn = 1'b0;
    mem.preload(28'h100000, 1024);
    t = 0;
    while (rst_b !== 1'b1 && t < 100) begin
      @(posedge clk);
      t++;
    end
    if (rst_b !== 1'b1) begin
      $display("reset was never released");
      errors++;
    end
    repeat (2) @(negedge clk);

    // 1: plain word copy
    mem.clearLog();
    buildExpected(28'h100000, 28'h200000, 16, ADDR_INC, ADDR_INC, 1'b1, 1);
    runTransfer(0, makeCfg(28'h100000, 28'h200000, 16, ADDR_INC, ADDR_INC, 0, 1,
                           START_NOW), 500, "wordCopy");
    checkRegion("wordCopy", 28'h200000, 28'h210000);
    for (int k = 0; k < 16; k++) begin
      checks++;
      if (mem.peekWord(28'h200000 + 4 * k) != mem.peekWord(28'h100000 + 4 * k)) begin
        $display("mismatch wordCopyMem exp %h got %h", mem.peekWord(28'h100000 + 4 * k),
                 mem.peekWord(28'h200000 + 4 * k));
        errors++;
      end
    end

    // 2: halfword copies, mixed modes
    stallEn = 1'b1;
    for (int it = 0; it < 6; it++) begin
      sm = addrModeT'($urandom % 3);
      dm = addrModeT'(it % 4);  // every destination mode comes up
      n0 = 4 + $urandom % 9;
      src = 28'h100400 + 2 * ($urandom % 128);
      dst = 28'h240040 + 28'h100 * it + 2 * ($urandom % 16);
      mem.clearLog();
      buildExpected(src, dst, n0, sm, dm, 1'b0, 1);
      runTransfer(1, makeCfg(src, dst, n0, sm, dm, 0, 0, START_NOW), 500, "halfCopy");
      checkRegion("halfCopy", 28'h240000, 28'h250000);
    end

    // 3: long transfer under stalls
    mem.clearLog();
    buildExpected(28'h100000, 28'h280000, 200, ADDR_INC, ADDR_INC, 1'b1, 1);
    runTransfer(2, makeCfg(28'h100000, 28'h280000, 200, ADDR_INC, ADDR_INC, 0, 1,
                           START_NOW), 5000, "longStall");
    checkRegion("longStall", 28'h280000, 28'h290000);
    checks++;
    if (mem.logAddr.size() != 200) begin
      $display("mismatch longStall count exp 200 got %0d", mem.logAddr.size());
      errors++;
    end

    // 4: channel 0 cuts into channel 3
    mem.clearLog();
    @(negedge clk) cfg[3] = makeCfg(28'h100000, 28'h300000, 40, ADDR_INC, ADDR_INC, 0, 1,
                                    START_NOW);
    waitWrites(5, 500, "priority");
    checks++;
    if (active !== 1'b1) begin
      $display("mismatch priority active exp 1 got %b", active);
      errors++;
    end
    @(negedge clk) cfg[0] = makeCfg(28'h100200, 28'h380000, 6, ADDR_INC, ADDR_INC, 0, 1,
                                    START_NOW);
    waitPulse(0, 1'b0, 500, "priority");
    @(negedge clk) cfg[0].enable = 1'b0;
    waitPulse(3, 1'b0, 2000, "priority");
    @(negedge clk) cfg[3].enable = 1'b0;
    first = -1;
    last = -1;
    n0 = 0;
    n3 = 0;
    for (int i = 0; i < mem.logAddr.size(); i++) begin
      if (mem.logAddr[i] >= 28'h380000) begin
        if (first < 0) first = i;
        last = i;
        n0++;
      end else begin
        n3++;
      end
    end
    checks++;
    if (n0 != 6 || last - first + 1 != 6) begin
      $display("priority: channel 0 writes are not one block of 6 (%0d..%0d)", first, last);
      errors++;
    end
    if (n3 != 40) begin
      $display("mismatch priority ch3Count exp 40 got %0d", n3);
      errors++;
    end
    buildExpected(28'h100200, 28'h380000, 6, ADDR_INC, ADDR_INC, 1'b1, 1);
    checkRegion("priorityCh0", 28'h380000, 28'h390000);
    buildExpected(28'h100000, 28'h300000, 40, ADDR_INC, ADDR_INC, 1'b1, 1);
    checkRegion("priorityCh3", 28'h300000, 28'h310000);

    // 5a: one-shot completion pulses
    i0 = irqCnt[1];
    d0 = disCnt[1];
    runTransfer(1, makeCfg(28'h100000, 28'h2c0000, 4, ADDR_INC, ADDR_INC, 0, 1,
                           START_NOW), 500, "oneShot");
    repeat (20) @(negedge clk);
    checks++;
    if (irqCnt[1] - i0 != 1 || disCnt[1] - d0 != 1) begin
      $display("mismatch oneShot pulses exp 1/1 got %0d/%0d", irqCnt[1] - i0,
               disCnt[1] - d0);
      errors++;
    end

    // 5b: repeating hblank channel
    mem.clearLog();
    d0 = disCnt[2];
    @(negedge clk) cfg[2] = makeCfg(28'h100000, 28'h2d0000, 3, ADDR_INC, ADDR_INC_RELOAD,
                                    1, 1, START_HBLANK);
    repeat (3) @(negedge clk);
    for (int p = 0; p < 2; p++) begin
      fork
        pulseHblank();
        waitPulse(2, 1'b1, 500, "hblankRepeat");
      join
    end
    @(negedge clk) cfg[2].enable = 1'b0;
    buildExpected(28'h100000, 28'h2d0000, 3, ADDR_INC, ADDR_INC_RELOAD, 1'b1, 2);
    checkRegion("hblankRepeat", 28'h2d0000, 28'h2e0000);
    checks++;
    if (disCnt[2] != d0) begin
      $display("mismatch hblankRepeat disable exp 0 got %0d", disCnt[2] - d0);
      errors++;
    end

    // 6: sound fifo pacing on channel 1
    mem.clearLog();
    @(negedge clk) cfg[1] = makeCfg(28'h100800, 28'h2e0000, 1, ADDR_INC, ADDR_INC, 1, 0,
                                    START_SPECIAL);
    repeat (3) @(negedge clk);
    for (int p = 0; p < 5; p++) begin
      fork
        begin
          @(negedge clk) soundReq = 2'b01;
          @(negedge clk) soundReq = 2'b00;
        end
        waitPulse(1, 1'b1, 200, "soundFifo");
      join
      repeat (3) @(negedge clk);
    end
    @(negedge clk) cfg[1].enable = 1'b0;
    buildExpected(28'h100800, 28'h2e0000, 1, ADDR_INC, ADDR_FIXED, 1'b1, 5);
    checkRegion("soundFifo", 28'h2e0000, 28'h2f0000);

    repeat (5) @(negedge clk);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
design/dmaPkg.sv
design/dmaStartSync.sv
design/dmaChannel.sv
design/dmaBusArbiter.sv
design/dmaTop.sv
bench/dmaClockGen.sv
bench/dmaMemModel.sv
bench/dmaTb.sv

// File: Bender.yml
package:
  name: dma
  authors: []

dependencies: {}

sources:
  - files:
      - design/dmaPkg.sv
      - design/dmaStartSync.sv
      - design/dmaChannel.sv
      - design/dmaBusArbiter.sv
      - design/dmaTop.sv
  - target: test
    files:
      - bench/dmaClockGen.sv
      - bench/dmaMemModel.sv
      - bench/dmaTb.sv
